// File: build.f
design/sat_pkg.sv
design/flow_pkg.sv
design/clause_stream_if.sv
design/clause_evaluator.sv
design/break_counter.sv
design/temporal_buffer.sv
design/heuristic_selector.sv
design/result_sender.sv
design/flip_eval_top.sv
tb/flip_eval_props.sv
tb/flip_eval_tb.sv

// File: tb/flip_eval_tb.sv
`timescale 1ns/1ps

module flip_eval_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 5;
    localparam int DRIVE_DELAY     = 1;      // inputs change this long after the edge
    localparam int MAX_BEATS       = 12;     // longest random round
    localparam int TOTAL_ROUNDS    = 40;     // upper bound over all tests
    localparam int WATCHDOG_CYCLES = TOTAL_ROUNDS * MAX_BEATS * 20;
    localparam int MODE_RANDOM     = 0;      // any true count
    localparam int MODE_NO_BREAK   = 1;      // true count never one
    localparam int MODE_TIE        = 2;      // every flip breaks equally often
    localparam int MODE_STALE      = 3;      // flip 0 breaks, round left open
    localparam int MODE_NO_FLIP0   = 4;      // breaks only on flips 1 and 2

    typedef struct packed {
        logic                                  last;
        sat_pkg::true_count_t                  true_count;
        sat_pkg::literal_t [sat_pkg::NSAT-2:0] other_lit;
        sat_pkg::literal_t                     flipped_lit;
        sat_pkg::flip_idx_t                    flip;
    } beat_t;

    typedef struct packed {
        sat_pkg::flip_idx_t                    flip;
        sat_pkg::break_count_t                 count;
        sat_pkg::literal_t [sat_pkg::NSAT-1:0] clause;
    } result_t;

    logic                                  clk;
    logic                                  reset;
    logic                                  in_valid_i;
    sat_pkg::flip_idx_t                    in_flip_i;
    sat_pkg::literal_t                     in_flipped_lit_i;
    sat_pkg::literal_t [sat_pkg::NSAT-2:0] in_other_lit_i;
    sat_pkg::true_count_t                  in_true_count_i;
    logic                                  in_last_i;
    logic                                  in_credit_o;
    logic                                  out_valid_o;
    sat_pkg::flip_idx_t                    out_flip_o;
    sat_pkg::break_count_t                 out_break_count_o;
    sat_pkg::literal_t [sat_pkg::NSAT-1:0] out_clause_o;
    logic                                  out_credit_i;

    beat_t       beat_q[$];                  // beats not yet sent upstream
    result_t     expect_q[$];                // model results in send order
    int          up_credits;                 // free slots as upstream sees them
    int          down_in_use;                // results sent, credit not yet back
    bit          withhold;                   // downstream keeps its credits
    int          send_pct;                   // chance of a beat in a cycle
    int          results_seen;
    int          errors;
    int          checks;
    int          tests_run;
    int          test_start_errors;
    logic [31:0] rng_state = 32'h409ee22c;

    flip_eval_top dut (.*);

    bind clause_evaluator flip_eval_props #(.MAX_COUNT(flow_pkg::IN_CREDITS)) u_in_props (
        .clk(clk), .reset(reset), .count_i(q_count),
        .add_i(in_valid_i), .return_i(in_credit_o)
    );
    bind result_sender flip_eval_props #(.MAX_COUNT(flow_pkg::OUT_CREDITS)) u_out_props (
        .clk(clk), .reset(reset), .count_i(out_credit_cnt),
        .add_i(send), .return_i(out_credit_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 8) % n);  // low bits of an LCG are weak
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    // builds one round, queues its beats and the model's result
    task automatic add_round(input int n_beats, input int mode);
        int                                    counts [sat_pkg::NSAT];
        sat_pkg::literal_t [sat_pkg::NSAT-1:0] last_clause [sat_pkg::NSAT];
        int                                    best;
        beat_t                                 b;
        result_t                               r;
        for (int f = 0; f < sat_pkg::NSAT; f++) begin
            counts[f]      = 0;
            last_clause[f] = '0;  // no break leaves the row empty
        end
        for (int i = 0; i < n_beats; i++) begin
            b.flip         = sat_pkg::flip_idx_t'(rand_below(sat_pkg::NSAT));
            b.flipped_lit  = sat_pkg::literal_t'(lcg_next() >> 5);
            b.other_lit[0] = sat_pkg::literal_t'(lcg_next() >> 5);
            b.other_lit[1] = sat_pkg::literal_t'(lcg_next() >> 5);
            b.true_count   = sat_pkg::true_count_t'(rand_below(4));
            b.last         = (i == n_beats - 1) && (mode != MODE_STALE);
            case (mode)
                MODE_NO_BREAK: b.true_count = (rand_below(2) == 0) ? 2'd0 : 2'd2 + rand_below(2);
                MODE_TIE: begin
                    b.flip       = sat_pkg::flip_idx_t'(i % sat_pkg::NSAT);
                    b.true_count = 2'd1;
                end
                MODE_STALE: begin
                    b.flip       = '0;
                    b.true_count = 2'd1;
                end
                MODE_NO_FLIP0: begin
                    b.flip       = sat_pkg::flip_idx_t'(1 + rand_below(2));
                    b.true_count = 2'd1;
                end
                default: ;
            endcase
            if (b.true_count == 2'd1) begin  // flipped literal was the only support
                counts[b.flip]++;
                last_clause[b.flip] = {b.other_lit[1], b.other_lit[0], b.flipped_lit};
            end
            beat_q.push_back(b);
        end
        best = 0;
        for (int f = 1; f < sat_pkg::NSAT; f++) begin
            if (counts[f] < counts[best]) best = f;  // earlier flip keeps a tie
        end
        r.flip   = sat_pkg::flip_idx_t'(best);
        r.count  = sat_pkg::break_count_t'((counts[best] > 255) ? 255 : counts[best]);
        r.clause = last_clause[best];
        if (mode != MODE_STALE) expect_q.push_back(r);
    endtask

    // one clock cycle of upstream, downstream and result checking
    task automatic step_cycle();
        beat_t   b;
        result_t want;
        int      returnable;
        @(posedge clk);
        #DRIVE_DELAY;
        if (in_credit_o === 1'b1) begin
            up_credits++;
            if (up_credits > flow_pkg::IN_CREDITS) report_error("input credit beyond the grant");
        end
        returnable = down_in_use;  // results of earlier cycles only
        if (out_valid_o === 1'b1) begin
            results_seen++;
            if (down_in_use >= flow_pkg::OUT_CREDITS) report_error("result sent without credit");
            down_in_use++;
            if (expect_q.size() == 0) begin
                report_error("result sent when none was expected");
            end else begin
                want = expect_q.pop_front();
                check_value(out_flip_o, want.flip, "selected flip");
                check_value(out_break_count_o, want.count, "break count");
                check_value(out_clause_o, want.clause, "stored clause");
            end
        end
        out_credit_i = 1'b0;
        if (!withhold && returnable > 0 && rand_below(3) == 0) begin  // random return delay
            out_credit_i = 1'b1;
            down_in_use--;
        end
        in_valid_i = 1'b0;
        if (beat_q.size() > 0 && up_credits > 0 && rand_below(100) < send_pct) begin
            b                = beat_q.pop_front();
            in_valid_i       = 1'b1;
            in_flip_i        = b.flip;
            in_flipped_lit_i = b.flipped_lit;
            in_other_lit_i   = b.other_lit;
            in_true_count_i  = b.true_count;
            in_last_i        = b.last;
            up_credits--;
        end
    endtask

    task automatic run_until_drained();
        while (beat_q.size() > 0 || expect_q.size() > 0 || down_in_use > 0 ||
               up_credits != flow_pkg::IN_CREDITS) begin
            step_cycle();
        end
        repeat (4) step_cycle();  // quiet tail, catches stray results
    endtask

    task automatic apply_reset();
        reset        = 1'b1;
        in_valid_i   = 1'b0;
        out_credit_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset        = 1'b0;
        beat_q.delete();
        expect_q.delete();
        up_credits   = flow_pkg::IN_CREDITS;  // granted again after reset
        down_in_use  = 0;
    endtask

    task automatic finish_test(input string name);
        $display("test %-20s %0d errors", name, errors - test_start_errors);
        tests_run++;
        test_start_errors = errors;
    endtask

    initial begin
        in_valid_i        = 1'b0;
        in_flip_i         = '0;
        in_flipped_lit_i  = '0;
        in_other_lit_i    = '0;
        in_true_count_i   = '0;
        in_last_i         = 1'b0;
        out_credit_i      = 1'b0;
        withhold          = 1'b0;
        send_pct          = 100;
        results_seen      = 0;
        errors            = 0;
        checks            = 0;
        tests_run         = 0;
        test_start_errors = 0;
        apply_reset();
        check_value(out_valid_o, 1'b0, "out_valid_o after reset");
        check_value(in_credit_o, 1'b0, "in_credit_o after reset");
        finish_test("reset_idle");

        send_pct = 70;  // gaps between beats
        for (int r = 0; r < 20; r++) add_round(1 + rand_below(MAX_BEATS), MODE_RANDOM);
        run_until_drained();
        finish_test("random_rounds");

        send_pct = 100;
        for (int r = 0; r < 4; r++) add_round(1 + rand_below(MAX_BEATS), MODE_NO_BREAK);
        run_until_drained();
        finish_test("no_break_rounds");

        for (int r = 0; r < 4; r++) add_round(3 * (1 + rand_below(3)), MODE_TIE);
        run_until_drained();
        finish_test("tie_rounds");

        withhold = 1'b1;  // two results go out, the third waits in the holding register
        begin
            int sent_before;
            sent_before = results_seen;
            for (int r = 0; r < 6; r++) add_round(1 + rand_below(3), MODE_RANDOM);
            repeat (60) step_cycle();
            check_value(results_seen - sent_before, flow_pkg::OUT_CREDITS, "results sent");
            check_value(up_credits, 0, "upstream credits while stalled");
            check_value(expect_q.size(), 6 - flow_pkg::OUT_CREDITS, "results still held");
        end
        withhold = 1'b0;
        run_until_drained();
        finish_test("output_backpressure");

        add_round(4, MODE_STALE);  // flip 0 breaks that reset must wipe
        while (beat_q.size() > 0) step_cycle();
        repeat (4) step_cycle();
        apply_reset();
        check_value(out_valid_o, 1'b0, "out_valid_o after reset");
        check_value(in_credit_o, 1'b0, "in_credit_o after reset");
        add_round(3, MODE_NO_FLIP0);
        run_until_drained();
        finish_test("reset_mid_round");

        errors += dut.u_evaluator.u_in_props.failures + dut.u_sender.u_out_props.failures;
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Error: watchdog expired before all tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: tb/flip_eval_props.sv
`timescale 1ns/1ps

module flip_eval_props #(
    parameter int MAX_COUNT = 2             // credits granted at reset
) (
    input logic              clk,
    input logic              reset,
    input flow_pkg::credit_t count_i,       // credit counter or queue fill
    input logic              add_i,         // item handed over against a credit
    input logic              return_i       // credit coming back
);

    int failures = 0;   // summed by the testbench at the end
    int outstanding;    // items handed over, credit not yet back

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(add_i) - int'(return_i);
        end
    end

    count_in_range: assert property (@(posedge clk) disable iff (reset)
        count_i <= MAX_COUNT)
    else begin
        failures++;
        $error("credit counter above its maximum");
    end

    // a credit coming back in the same cycle frees its slot
    spend_has_credit: assert property (@(posedge clk) disable iff (reset)
        add_i |-> (outstanding - int'(return_i)) < MAX_COUNT)
    else begin
        failures++;
        $error("item handed over with no credit left");
    end

    return_has_item: assert property (@(posedge clk) disable iff (reset)
        return_i |-> outstanding > 0)
    else begin
        failures++;
        $error("credit returned with no item outstanding");
    end

endmodule

// File: design/flip_eval_top.sv
`timescale 1ns/1ps

module flip_eval_top (
    input  logic                                  clk,
    input  logic                                  reset,
    // upstream beats
    input  logic                                  in_valid_i,
    input  sat_pkg::flip_idx_t                    in_flip_i,
    input  sat_pkg::literal_t                     in_flipped_lit_i,
    input  sat_pkg::literal_t [sat_pkg::NSAT-2:0] in_other_lit_i,
    input  sat_pkg::true_count_t                  in_true_count_i,
    input  logic                                  in_last_i,
    output logic                                  in_credit_o,
    // downstream result
    output logic                                  out_valid_o,
    output sat_pkg::flip_idx_t                    out_flip_o,
    output sat_pkg::break_count_t                 out_break_count_o,
    output sat_pkg::literal_t [sat_pkg::NSAT-1:0] out_clause_o,  // flipped literal first
    input  logic                                  out_credit_i
);

    sat_pkg::break_count_t [sat_pkg::NSAT-1:0] counts;      // counter to selector
    sat_pkg::flip_idx_t                        sel_flip;
    sat_pkg::break_count_t                     sel_count;
    sat_pkg::literal_t [sat_pkg::NSAT-1:0]     sel_clause;  // buffer row of the chosen flip
    logic                                      round_done;
    logic                                      hold_full;   // back pressure into the queue

    clause_stream_if stream ();

    assign round_done = stream.valid && stream.last;

    clause_evaluator u_evaluator (
        .clk              (clk),
        .reset            (reset),
        .in_valid_i       (in_valid_i),
        .in_flip_i        (in_flip_i),
        .in_flipped_lit_i (in_flipped_lit_i),
        .in_other_lit_i   (in_other_lit_i),
        .in_true_count_i  (in_true_count_i),
        .in_last_i        (in_last_i),
        .hold_full_i      (hold_full),
        .in_credit_o      (in_credit_o),
        .stream           (stream)
    );

    break_counter u_counter (
        .clk      (clk),
        .reset    (reset),
        .stream   (stream),
        .counts_o (counts)
    );

    temporal_buffer u_buffer (
        .clk        (clk),
        .reset      (reset),
        .stream     (stream),
        .sel_flip_i (sel_flip),
        .clause_o   (sel_clause)
    );

    heuristic_selector u_selector (
        .counts_i    (counts),
        .sel_flip_o  (sel_flip),
        .sel_count_o (sel_count)
    );

    result_sender u_sender (
        .clk               (clk),
        .reset             (reset),
        .round_done_i      (round_done),
        .sel_flip_i        (sel_flip),
        .sel_count_i       (sel_count),
        .clause_i          (sel_clause),
        .out_credit_i      (out_credit_i),
        .hold_full_o       (hold_full),
        .out_valid_o       (out_valid_o),
        .out_flip_o        (out_flip_o),
        .out_break_count_o (out_break_count_o),
        .out_clause_o      (out_clause_o)
    );

endmodule

// File: design/result_sender.sv
`timescale 1ns/1ps

module result_sender (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  round_done_i,      // last beat on the stream
    input  sat_pkg::flip_idx_t                    sel_flip_i,
    input  sat_pkg::break_count_t                 sel_count_i,
    input  sat_pkg::literal_t [sat_pkg::NSAT-1:0] clause_i,
    input  logic                                  out_credit_i,      // one credit back per pulse
    output logic                                  hold_full_o,       // stalls the next round end
    output logic                                  out_valid_o,
    output sat_pkg::flip_idx_t                    out_flip_o,
    output sat_pkg::break_count_t                 out_break_count_o,
    output sat_pkg::literal_t [sat_pkg::NSAT-1:0] out_clause_o
);

    flow_pkg::send_state_t state;
    flow_pkg::credit_t     out_credit_cnt;  // downstream slots still free
    logic                  capture;
    logic                  send;

    assign capture     = round_done_i && (state == flow_pkg::IDLE);
    assign send        = (state == flow_pkg::SEND);
    assign out_valid_o = send;
    // a round_done already on the stream claims the slot too
    assign hold_full_o = (state != flow_pkg::IDLE) || round_done_i;

    // one entry holding register, drives the outputs directly
    always_ff @(posedge clk) begin
        if (capture) begin
            out_flip_o        <= sel_flip_i;
            out_break_count_o <= sel_count_i;
            out_clause_o      <= clause_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= flow_pkg::IDLE;
        end else begin
            case (state)
                flow_pkg::IDLE: begin
                    if (round_done_i) begin
                        state <= flow_pkg::WAIT_CREDIT;
                    end
                end
                flow_pkg::WAIT_CREDIT: begin
                    if (out_credit_cnt != '0) begin  // leaves at once when a credit is free
                        state <= flow_pkg::SEND;
                    end
                end
                flow_pkg::SEND: state <= flow_pkg::IDLE;  // single cycle valid
                default:        state <= flow_pkg::IDLE;
            endcase
        end
    end

    // send and return may land on the same edge and cancel
    always_ff @(posedge clk) begin
        if (reset) begin
            out_credit_cnt <= flow_pkg::credit_t'(flow_pkg::OUT_CREDITS);
        end else if (send && !out_credit_i) begin
            out_credit_cnt <= out_credit_cnt - 1'b1;
        end else if (!send && out_credit_i) begin
            out_credit_cnt <= out_credit_cnt + 1'b1;
        end
    end

endmodule

// File: design/heuristic_selector.sv
`timescale 1ns/1ps

module heuristic_selector (
    input  sat_pkg::break_count_t [sat_pkg::NSAT-1:0] counts_i,
    output sat_pkg::flip_idx_t                        sel_flip_o,   // flip with fewest breaks
    output sat_pkg::break_count_t                     sel_count_o   // its break count
);

    // linear scan, three entries so depth is small
    always_comb begin
        sel_flip_o  = '0;           // flip 0 wins unless beaten
        sel_count_o = counts_i[0];
        for (int i = 1; i < sat_pkg::NSAT; i++) begin
            if (counts_i[i] < sel_count_o) begin  // strict, lower index keeps a tie
                sel_flip_o  = sat_pkg::flip_idx_t'(i);
                sel_count_o = counts_i[i];
            end
        end
    end

endmodule

// File: design/temporal_buffer.sv
`timescale 1ns/1ps

module temporal_buffer (
    input  logic                                   clk,
    input  logic                                   reset,
    clause_stream_if.sink                          stream,
    input  sat_pkg::flip_idx_t                     sel_flip_i,  // row picked by the selector
    output sat_pkg::literal_t [sat_pkg::NSAT-1:0]  clause_o     // [0] is the flipped literal
);

    sat_pkg::literal_t [sat_pkg::NSAT-1:0] rows [sat_pkg::NSAT];  // one row per flip
    sat_pkg::literal_t [sat_pkg::NSAT-1:0] beat_clause;           // clause of the current beat
    logic                                  write_en;
    logic                                  round_end;

    assign write_en  = stream.valid && stream.broken && (stream.flip < sat_pkg::NSAT);
    assign round_end = stream.valid && stream.last;

    always_comb begin
        beat_clause[0] = stream.flipped_lit;
        for (int i = 1; i < sat_pkg::NSAT; i++) begin
            beat_clause[i] = stream.other_lit[i-1];  // others follow in stream order
        end
    end

    always_ff @(posedge clk) begin
        if (reset || round_end) begin
            for (int r = 0; r < sat_pkg::NSAT; r++) begin
                rows[r] <= '0;  // empty row reads as all zero
            end
        end else if (write_en) begin
            rows[stream.flip] <= beat_clause;  // newest break replaces the older one
        end
    end

    // read port, same cycle write forwarded
    always_comb begin
        clause_o = rows[sel_flip_i];
        if (write_en && (stream.flip == sel_flip_i)) begin
            clause_o = beat_clause;
        end
    end

endmodule

// File: design/break_counter.sv
`timescale 1ns/1ps

module break_counter (
    input  logic                                      clk,
    input  logic                                      reset,
    clause_stream_if.sink                             stream,
    output sat_pkg::break_count_t [sat_pkg::NSAT-1:0] counts_o  // includes this cycle's break
);

    sat_pkg::break_count_t [sat_pkg::NSAT-1:0] counts;  // per flip, registered
    logic                                      flip_ok;
    logic                                      hit;
    logic                                      round_end;
    logic                                      at_max;

    assign flip_ok   = (stream.flip < sat_pkg::NSAT);     // index 3 names no flip
    assign hit       = stream.valid && stream.broken && flip_ok;
    assign round_end = stream.valid && stream.last;
    assign at_max    = (counts[stream.flip] == sat_pkg::BREAK_MAX);

    always_ff @(posedge clk) begin
        if (reset) begin
            counts <= '0;
        end else if (round_end) begin
            counts <= '0;  // next round starts clean
        end else if (hit && !at_max) begin
            counts[stream.flip] <= counts[stream.flip] + 1'b1;
        end
    end

    // bypass so the selector sees the last beat of the round
    always_comb begin
        counts_o = counts;
        if (hit && !at_max) begin
            counts_o[stream.flip] = counts[stream.flip] + 1'b1;
        end
    end

endmodule

// File: design/clause_evaluator.sv
`timescale 1ns/1ps

module clause_evaluator (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_valid_i,        // only sent against a credit
    input  sat_pkg::flip_idx_t                    in_flip_i,
    input  sat_pkg::literal_t                     in_flipped_lit_i,
    input  sat_pkg::literal_t [sat_pkg::NSAT-2:0] in_other_lit_i,
    input  sat_pkg::true_count_t                  in_true_count_i,
    input  logic                                  in_last_i,
    input  logic                                  hold_full_i,       // result slot busy
    output logic                                  in_credit_o,       // one pulse per popped beat
    clause_stream_if.src                          stream
);

    // two entry beat queue, sized by the credits handed upstream
    sat_pkg::flip_idx_t                    q_flip    [flow_pkg::IN_CREDITS];
    sat_pkg::literal_t                     q_flipped [flow_pkg::IN_CREDITS];
    sat_pkg::literal_t [sat_pkg::NSAT-2:0] q_other   [flow_pkg::IN_CREDITS];
    sat_pkg::true_count_t                  q_true    [flow_pkg::IN_CREDITS];
    logic                                  q_last    [flow_pkg::IN_CREDITS];

    logic [flow_pkg::IN_PTR_WIDTH-1:0] wr_ptr;
    logic [flow_pkg::IN_PTR_WIDTH-1:0] rd_ptr;
    flow_pkg::credit_t                 q_count;  // beats waiting
    logic                              q_empty;
    logic                              stall;
    logic                              pop;

    assign q_empty = (q_count == '0);
    assign stall   = q_last[rd_ptr] && hold_full_i;  // round end waits for a free result slot
    assign pop     = !q_empty && !stall;             // one beat per cycle otherwise

    always_ff @(posedge clk) begin
        if (in_valid_i) begin  // upstream never overruns, credit guarantees a slot
            q_flip[wr_ptr]    <= in_flip_i;
            q_flipped[wr_ptr] <= in_flipped_lit_i;
            q_other[wr_ptr]   <= in_other_lit_i;
            q_true[wr_ptr]    <= in_true_count_i;
            q_last[wr_ptr]    <= in_last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (in_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth 2
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({in_valid_i, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;  // push and pop together, or nothing
            endcase
        end
    end

    // evaluation register, control part
    always_ff @(posedge clk) begin
        if (reset) begin
            stream.valid <= 1'b0;
            stream.last  <= 1'b0;
            in_credit_o  <= 1'b0;
        end else begin
            stream.valid <= pop;
            stream.last  <= pop && q_last[rd_ptr];
            in_credit_o  <= pop;  // slot freed, hand the credit back
        end
    end

    // evaluation register, payload and break decision
    always_ff @(posedge clk) begin
        if (pop) begin
            stream.flip        <= q_flip[rd_ptr];
            stream.broken      <= (q_true[rd_ptr] == sat_pkg::BREAK_TRUE_COUNT);
            stream.flipped_lit <= q_flipped[rd_ptr];
            stream.other_lit   <= q_other[rd_ptr];
        end
    end

endmodule

// File: design/clause_stream_if.sv
`timescale 1ns/1ps

interface clause_stream_if;

    logic                                  valid;        // one evaluated beat this cycle
    logic                                  last;         // beat closes the round
    sat_pkg::flip_idx_t                    flip;         // candidate flip of the beat
    logic                                  broken;       // clause true count was one
    sat_pkg::literal_t                     flipped_lit;  // literal the flip makes false
    sat_pkg::literal_t [sat_pkg::NSAT-2:0] other_lit;    // remaining clause literals

    // evaluator side
    modport src (
        output valid, last, flip, broken, flipped_lit, other_lit
    );

    // counter and buffer side, always ready
    modport sink (
        input valid, last, flip, broken, flipped_lit, other_lit
    );

endinterface

// File: design/flow_pkg.sv
package flow_pkg;

    localparam int IN_CREDITS   = 2;                        // input queue depth
    localparam int OUT_CREDITS  = 2;                        // downstream grants at reset
    localparam int IN_PTR_WIDTH = $clog2(IN_CREDITS);       // queue pointer bits
    localparam int CREDIT_WIDTH = $clog2(OUT_CREDITS + 1);  // holds 0..OUT_CREDITS

    typedef logic [CREDIT_WIDTH-1:0] credit_t;

    // result send FSM
    typedef enum logic [1:0] {
        IDLE,         // holding register empty
        WAIT_CREDIT,  // result held, no downstream credit yet
        SEND          // out_valid_o high this cycle
    } send_state_t;

endpackage

// File: design/sat_pkg.sv
package sat_pkg;

    localparam int NSAT                  = 3;             // literals per clause, flips per round
    localparam int LITERAL_ADDRESS_WIDTH = 11;            // variable address bits
    localparam int FLIP_IDX_WIDTH        = $clog2(NSAT);  // 2 bits cover flips 0..2
    localparam int TRUE_COUNT_WIDTH      = 2;             // 0..3 true literals
    localparam int BREAK_COUNT_WIDTH     = 8;

    // literal layout is {variable address, polarity}
    typedef logic [LITERAL_ADDRESS_WIDTH:0]   literal_t;
    typedef logic [FLIP_IDX_WIDTH-1:0]        flip_idx_t;     // which candidate flip
    typedef logic [TRUE_COUNT_WIDTH-1:0]      true_count_t;   // true literals in a clause
    typedef logic [BREAK_COUNT_WIDTH-1:0]     break_count_t;  // breaks caused by one flip

    localparam break_count_t BREAK_MAX        = '1;  // counters stick at 255
    localparam true_count_t  BREAK_TRUE_COUNT = 1;   // flipped literal is the only support

endpackage
